// ==== filelist.f ====
hdl/udp_echo_pkg.sv
hdl/frame_fifo.sv
hdl/udp_hdr_parser.sv
hdl/rx_admit_ctrl.sv
hdl/reply_tx_framer.sv
hdl/udp_echo_top.sv
tests/tb_udp_echo_assert.sv
tests/tb_udp_echo.sv

// ==== hdl/frame_fifo.sv ====
// Synchronous valid/ready FIFO for any item type, used for reply headers and payload bytes
module frame_fifo #(
    parameter type item_t = logic [7:0],
    parameter int  DEPTH  = 16
) (
    input  logic  clk,
    input  logic  rst,

    input  item_t in_item,
    input  logic  in_valid,
    output logic  in_ready,

    output item_t out_item,
    output logic  out_valid,
    input  logic  out_ready
);

    localparam int AW = $clog2(DEPTH);

    item_t mem [DEPTH];

    // Extra top bit tells full from empty
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic        full;
    logic        empty;

    assign empty = (wr_ptr == rd_ptr);
    assign full = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    assign in_ready = !full;
    assign out_valid = !empty;
    assign out_item = mem[rd_ptr[AW-1:0]];

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            mem[wr_ptr[AW-1:0]] <= in_item;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (in_valid && in_ready) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (out_valid && out_ready) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

// ==== hdl/reply_tx_framer.sv ====
// Builds each reply frame, header bytes with a fresh IPv4 checksum followed by the queued payload
module reply_tx_framer (
    input  logic                        clk,
    input  logic                        rst,

    input  udp_echo_pkg::mac_addr_t     local_mac,
    input  udp_echo_pkg::ip_addr_t      local_ip,

    input  udp_echo_pkg::reply_hdr_t    hdr,
    input  logic                        hdr_valid,
    output logic                        hdr_ready,

    input  udp_echo_pkg::payload_beat_t pay,
    input  logic                        pay_valid,
    output logic                        pay_ready,

    output logic [7:0]                  m_tdata,
    output logic                        m_tvalid,
    output logic                        m_tlast,
    output logic                        m_tuser,
    input  logic                        m_tready
);

    logic                               active;
    logic [udp_echo_pkg::HDR_IDX_W-1:0] idx;
    logic [15:0]                        csum;
    logic                               hdr_phase;
    logic [8*udp_echo_pkg::HDR_LEN-1:0] hdr_bytes;

    // Ones'-complement sum of the ten header words, checksum word as zero
    function automatic logic [15:0] ip_checksum(
        input logic [15:0]            len,
        input udp_echo_pkg::ip_addr_t src,
        input udp_echo_pkg::ip_addr_t dst
    );
        logic [19:0] sum;
        sum = {udp_echo_pkg::IP_VER_IHL, 8'h00} + len +
              {udp_echo_pkg::REPLY_TTL, udp_echo_pkg::IP_PROTO_UDP} +
              src[31:16] + src[15:0] + dst[31:16] + dst[15:0];
        // Two folds absorb every carry
        sum = sum[15:0] + sum[19:16];
        sum = sum[15:0] + sum[19:16];
        return ~sum[15:0];
    endfunction

    assign hdr_phase = (idx != udp_echo_pkg::HDR_IDX_W'(udp_echo_pkg::HDR_LEN));

    // Whole reply header, first byte on the wire in the top bits
    assign hdr_bytes = {
        hdr.dest_mac,
        local_mac,
        udp_echo_pkg::ETHERTYPE_IPV4,
        udp_echo_pkg::IP_VER_IHL,
        8'h00,
        hdr.ip_length,
        16'h0000,
        16'h0000,
        udp_echo_pkg::REPLY_TTL,
        udp_echo_pkg::IP_PROTO_UDP,
        csum,
        local_ip,
        hdr.dest_ip,
        hdr.src_port,
        hdr.dest_port,
        hdr.udp_length,
        16'h0000
    };

    // Header stays at the FIFO head until the reply is finished
    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
            idx <= '0;
        end else if (!active) begin
            if (hdr_valid) begin
                active <= 1'b1;
                idx <= '0;
            end
        end else if (hdr_phase) begin
            if (m_tready) begin
                idx <= idx + 1'b1;
            end
        end else if (pay_valid && m_tready && pay.last) begin
            active <= 1'b0;
        end
    end

    // Computed once per reply while the framer is starting up
    always_ff @(posedge clk) begin
        if (!active && hdr_valid) begin
            csum <= ip_checksum(hdr.ip_length, local_ip, hdr.dest_ip);
        end
    end

    always_comb begin
        if (hdr_phase) begin
            m_tdata = hdr_bytes[8*(udp_echo_pkg::HDR_LEN - 1 - int'(idx)) +: 8];
        end else begin
            m_tdata = pay.data;
        end
    end

    assign m_tvalid = active && (hdr_phase || pay_valid);
    assign m_tlast = active && !hdr_phase && pay.last;
    assign m_tuser = active && !hdr_phase && pay.user;

    assign pay_ready = active && !hdr_phase && m_tready;
    assign hdr_ready = pay_ready && pay_valid && pay.last;

endmodule

// ==== hdl/rx_admit_ctrl.sv ====
// Receive admission control, steers accepted frames into the header and payload FIFOs
module rx_admit_ctrl (
    input  logic                        clk,
    input  logic                        rst,

    input  logic                        s_tvalid,
    input  logic                        s_tlast,
    input  logic                        s_tuser,
    input  logic [7:0]                  s_tdata,
    output logic                        s_tready,
    output logic                        beat,

    input  logic                        hdr_match,
    input  logic                        hdr_reject,
    output logic                        hdr_push,
    input  logic                        hdr_space,

    output logic                        pay_push,
    output udp_echo_pkg::payload_beat_t pay_beat,
    input  logic                        pay_space
);

    // Set while the payload of a matching frame is passing
    logic admitted;

    // Rejected and header bytes flow freely, a match waits for a header slot
    assign s_tready = admitted ? pay_space : (!hdr_match || hdr_space);
    assign beat = s_tvalid && s_tready;

    assign hdr_push = beat && hdr_match;
    assign pay_push = beat && admitted;

    assign pay_beat.data = s_tdata;
    assign pay_beat.last = s_tlast;
    assign pay_beat.user = s_tuser;

    always_ff @(posedge clk) begin
        if (rst) begin
            admitted <= 1'b0;
        end else if (beat) begin
            if (admitted && s_tlast) begin
                admitted <= 1'b0;
            end else if (hdr_match) begin
                admitted <= 1'b1;
            end
        end
    end

endmodule

// ==== hdl/udp_echo_pkg.sv ====
// Protocol constants, FIFO sizes and item types shared by the UDP echo responder modules
package udp_echo_pkg;

    // Header layout
    localparam int HDR_LEN = 42;
    localparam int HDR_IDX_W = $clog2(HDR_LEN + 1);

    // Fixed protocol field values
    localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
    localparam logic [7:0] IP_VER_IHL = 8'h45;
    localparam logic [7:0] IP_PROTO_UDP = 8'd17;
    localparam logic [7:0] REPLY_TTL = 8'd64;

    // Buffering
    localparam int PAYLOAD_FIFO_DEPTH = 2048;
    localparam int HDR_FIFO_DEPTH = 4;

    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;

    // One payload byte as stored in the payload FIFO
    typedef struct packed {
        logic [7:0] data;
        logic       last;
        logic       user;
    } payload_beat_t;

    // Per-reply header fields, everything else in the reply is constant
    typedef struct packed {
        mac_addr_t   dest_mac;
        ip_addr_t    dest_ip;
        udp_port_t   src_port;
        udp_port_t   dest_port;
        logic [15:0] ip_length;
        logic [15:0] udp_length;
    } reply_hdr_t;

endpackage

// ==== hdl/udp_echo_top.sv ====
// UDP echo responder top level, frames in on one byte stream and replies out on another
module udp_echo_top (
    input  logic                    clk,
    input  logic                    rst,

    // Local configuration, held stable while frames are in flight
    input  udp_echo_pkg::mac_addr_t local_mac,
    input  udp_echo_pkg::ip_addr_t  local_ip,
    input  udp_echo_pkg::udp_port_t udp_port,

    input  logic [7:0]              s_tdata,
    input  logic                    s_tvalid,
    output logic                    s_tready,
    input  logic                    s_tlast,
    input  logic                    s_tuser,

    output logic [7:0]              m_tdata,
    output logic                    m_tvalid,
    input  logic                    m_tready,
    output logic                    m_tlast,
    output logic                    m_tuser
);

    logic beat;
    logic hdr_match;
    logic hdr_reject;

    udp_echo_pkg::reply_hdr_t reply;
    udp_echo_pkg::reply_hdr_t hdr_head;
    logic                     hdr_push;
    logic                     hdr_space;
    logic                     hdr_valid;
    logic                     hdr_ready;

    udp_echo_pkg::payload_beat_t pay_in;
    udp_echo_pkg::payload_beat_t pay_head;
    logic                        pay_push;
    logic                        pay_space;
    logic                        pay_valid;
    logic                        pay_ready;

    udp_hdr_parser parser (
        .clk        (clk),
        .rst        (rst),
        .beat       (beat),
        .s_tdata    (s_tdata),
        .s_tlast    (s_tlast),
        .local_ip   (local_ip),
        .udp_port   (udp_port),
        .hdr_match  (hdr_match),
        .hdr_reject (hdr_reject),
        .reply      (reply)
    );

    rx_admit_ctrl admit (
        .clk        (clk),
        .rst        (rst),
        .s_tvalid   (s_tvalid),
        .s_tlast    (s_tlast),
        .s_tuser    (s_tuser),
        .s_tdata    (s_tdata),
        .s_tready   (s_tready),
        .beat       (beat),
        .hdr_match  (hdr_match),
        .hdr_reject (hdr_reject),
        .hdr_push   (hdr_push),
        .hdr_space  (hdr_space),
        .pay_push   (pay_push),
        .pay_beat   (pay_in),
        .pay_space  (pay_space)
    );

    frame_fifo #(
        .item_t (udp_echo_pkg::reply_hdr_t),
        .DEPTH  (udp_echo_pkg::HDR_FIFO_DEPTH)
    ) hdr_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_item   (reply),
        .in_valid  (hdr_push),
        .in_ready  (hdr_space),
        .out_item  (hdr_head),
        .out_valid (hdr_valid),
        .out_ready (hdr_ready)
    );

    frame_fifo #(
        .item_t (udp_echo_pkg::payload_beat_t),
        .DEPTH  (udp_echo_pkg::PAYLOAD_FIFO_DEPTH)
    ) payload_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_item   (pay_in),
        .in_valid  (pay_push),
        .in_ready  (pay_space),
        .out_item  (pay_head),
        .out_valid (pay_valid),
        .out_ready (pay_ready)
    );

    reply_tx_framer framer (
        .clk       (clk),
        .rst       (rst),
        .local_mac (local_mac),
        .local_ip  (local_ip),
        .hdr       (hdr_head),
        .hdr_valid (hdr_valid),
        .hdr_ready (hdr_ready),
        .pay       (pay_head),
        .pay_valid (pay_valid),
        .pay_ready (pay_ready),
        .m_tdata   (m_tdata),
        .m_tvalid  (m_tvalid),
        .m_tlast   (m_tlast),
        .m_tuser   (m_tuser),
        .m_tready  (m_tready)
    );

endmodule

// ==== hdl/udp_hdr_parser.sv ====
// Tracks the header byte position of incoming frames, captures the fields and judges the match
module udp_hdr_parser (
    input  logic                     clk,
    input  logic                     rst,

    input  logic                     beat,
    input  logic [7:0]               s_tdata,
    input  logic                     s_tlast,

    input  udp_echo_pkg::ip_addr_t   local_ip,
    input  udp_echo_pkg::udp_port_t  udp_port,

    output logic                     hdr_match,
    output logic                     hdr_reject,
    output udp_echo_pkg::reply_hdr_t reply
);

    // Byte position, parks at HDR_LEN for the payload
    logic [udp_echo_pkg::HDR_IDX_W-1:0] idx;

    udp_echo_pkg::mac_addr_t src_mac;
    logic [15:0]             eth_type;
    logic [7:0]              ver_ihl;
    logic [15:0]             ip_length;
    logic [7:0]              protocol;
    udp_echo_pkg::ip_addr_t  src_ip;
    udp_echo_pkg::ip_addr_t  dst_ip;
    udp_echo_pkg::udp_port_t src_port;
    udp_echo_pkg::udp_port_t dst_port;
    logic [15:0]             udp_length;

    logic hdr_ok;
    logic last_hdr_byte;

    always_ff @(posedge clk) begin
        if (rst) begin
            idx <= '0;
        end else if (beat) begin
            if (s_tlast) begin
                idx <= '0;
            end else if (idx != udp_echo_pkg::HDR_LEN) begin
                idx <= idx + 1'b1;
            end
        end
    end

    // Multi-byte fields arrive MSB first, so shift them in
    always_ff @(posedge clk) begin
        if (beat) begin
            case (idx) inside
                [6:11]: src_mac <= {src_mac[39:0], s_tdata};
                [12:13]: eth_type <= {eth_type[7:0], s_tdata};
                14: ver_ihl <= s_tdata;
                [16:17]: ip_length <= {ip_length[7:0], s_tdata};
                23: protocol <= s_tdata;
                [26:29]: src_ip <= {src_ip[23:0], s_tdata};
                [30:33]: dst_ip <= {dst_ip[23:0], s_tdata};
                [34:35]: src_port <= {src_port[7:0], s_tdata};
                [36:37]: dst_port <= {dst_port[7:0], s_tdata};
                [38:39]: udp_length <= {udp_length[7:0], s_tdata};
                default: ;
            endcase
        end
    end

    // All fields are in place by the last header byte
    assign hdr_ok = (eth_type == udp_echo_pkg::ETHERTYPE_IPV4) &&
                    (ver_ihl == udp_echo_pkg::IP_VER_IHL) &&
                    (protocol == udp_echo_pkg::IP_PROTO_UDP) &&
                    (dst_ip == local_ip) &&
                    (dst_port == udp_port);

    assign last_hdr_byte = (idx == udp_echo_pkg::HDR_IDX_W'(udp_echo_pkg::HDR_LEN - 1));

    // Describe the byte on the input, the controller qualifies them with tvalid
    // A frame that ends on this byte has no payload and is dropped
    assign hdr_match = last_hdr_byte && hdr_ok && !s_tlast;
    assign hdr_reject = last_hdr_byte && !(hdr_ok && !s_tlast);

    // Addresses and ports swapped for the reply
    assign reply.dest_mac = src_mac;
    assign reply.dest_ip = src_ip;
    assign reply.src_port = dst_port;
    assign reply.dest_port = src_port;
    assign reply.ip_length = ip_length;
    assign reply.udp_length = udp_length;

endmodule

// ==== tests/tb_udp_echo.sv ====
// Directed testbench for the UDP echo responder, compiled together with the RTL from the file list
module tb_udp_echo;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [47:0] LOCAL_MAC = 48'h02_1a_2b_3c_4d_5e;
    localparam logic [31:0] LOCAL_IP = 32'hc0a8_010a;
    localparam logic [15:0] UDP_PORT = 16'd7;
    localparam logic [31:0] SEED = 32'h186d_7752;
    localparam int GOOD = 0;
    localparam int BAD_PORT = 1;
    localparam int BAD_IP = 2;
    localparam int BAD_TYPE = 3;
    localparam int BAD_PROTO = 4;
    // Worst case byte count over all tests, 20 cycles per byte
    localparam int TEST_BYTES = 62 + 5 * 62 + 135 + 6 * 342 + 2 * 62;
    localparam int WATCHDOG_CYCLES = TEST_BYTES * 20 + 2000;

    logic clk, rst, m_tready;
    logic [7:0] s_tdata, m_tdata;
    logic s_tvalid, s_tready, s_tlast, s_tuser, m_tvalid, m_tlast, m_tuser;
    logic rand_ready;
    logic [31:0] pay_rng, rdy_rng;
    int errors;

    // Beats as {user, last, data}
    logic [9:0] req_q [$];
    logic [9:0] exp_q [$];
    logic [9:0] got_q [$];

    udp_echo_top uut (
        .clk(clk), .rst(rst), .local_mac(LOCAL_MAC), .local_ip(LOCAL_IP), .udp_port(UDP_PORT),
        .s_tdata(s_tdata), .s_tvalid(s_tvalid), .s_tready(s_tready), .s_tlast(s_tlast),
        .s_tuser(s_tuser), .m_tdata(m_tdata), .m_tvalid(m_tvalid), .m_tready(m_tready),
        .m_tlast(m_tlast), .m_tuser(m_tuser)
    );

    bind udp_echo_top tb_udp_echo_assert asserts (.*);

    always #5 clk = ~clk;

    always @(negedge clk) begin
        rdy_rng = xorshift32(rdy_rng);
        m_tready = rand_ready ? (rdy_rng[0] | rdy_rng[3]) : 1'b1;
    end

    always @(posedge clk) begin
        if (!rst && m_tvalid && m_tready) begin
            got_q.push_back({m_tuser, m_tlast, m_tdata});
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles, replies stopped arriving", WATCHDOG_CYCLES);
        $display("TB FAILED");
        $finish;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            errors++;
            $display("ERROR %s: got 0x%h, expected 0x%h", name, got, expected);
        end
    endtask

    task automatic put_field(ref logic [7:0] q[$], input logic [47:0] value, input int nbytes);
        for (int i = nbytes - 1; i >= 0; i--) begin
            q.push_back(value[8*i +: 8]);
        end
    endtask

    // Queues one request and, when it should be echoed, the reply it must produce
    task automatic build_frame(input int pay_len, input int kind, input int cut_len,
                               input logic user, input int tag);
        logic [7:0] req [$];
        logic [7:0] rep [$];
        logic [47:0] peer_mac;
        logic [31:0] peer_ip, dst_ip;
        logic [15:0] peer_port, dst_port, ip_len, udp_len, eth_type;
        logic [7:0] proto;
        logic [19:0] sum;
        int n;
        peer_mac = 48'h02_00_5e_10_00_00 + 48'(tag);
        peer_ip = 32'h0a00_0002 + 32'(tag);
        peer_port = 16'hc350 + 16'(tag);
        ip_len = 16'(28 + pay_len);
        udp_len = 16'(8 + pay_len);
        dst_ip = (kind == BAD_IP) ? (LOCAL_IP ^ 32'h0000_0100) : LOCAL_IP;
        dst_port = (kind == BAD_PORT) ? (UDP_PORT + 16'd1) : UDP_PORT;
        eth_type = (kind == BAD_TYPE) ? 16'h0806 : 16'h0800;
        proto = (kind == BAD_PROTO) ? 8'd6 : 8'd17;
        put_field(req, LOCAL_MAC, 6);
        put_field(req, peer_mac, 6);
        put_field(req, eth_type, 2);
        put_field(req, 16'h4500, 2);
        put_field(req, ip_len, 2);
        put_field(req, 32'h1c46_4000, 4);
        put_field(req, {8'h80, proto, 16'hbeef}, 4);
        put_field(req, peer_ip, 4);
        put_field(req, dst_ip, 4);
        put_field(req, {peer_port, dst_port}, 4);
        put_field(req, {udp_len, 16'h0000}, 4);
        // Reply header with TTL 64 and a zero checksum word for now
        put_field(rep, peer_mac, 6);
        put_field(rep, LOCAL_MAC, 6);
        put_field(rep, 32'h0800_4500, 4);
        put_field(rep, ip_len, 2);
        put_field(rep, 32'h0000_0000, 4);
        put_field(rep, 32'h4011_0000, 4);
        put_field(rep, LOCAL_IP, 4);
        put_field(rep, peer_ip, 4);
        put_field(rep, {UDP_PORT, peer_port}, 4);
        put_field(rep, {udp_len, 16'h0000}, 4);
        for (int i = 0; i < pay_len; i++) begin
            pay_rng = xorshift32(pay_rng);
            req.push_back(pay_rng[7:0]);
            rep.push_back(pay_rng[7:0]);
        end
        // IPv4 header occupies bytes 14 to 33
        sum = '0;
        for (int i = 14; i < 34; i += 2) begin
            sum = sum + {rep[i], rep[i+1]};
        end
        sum = sum[15:0] + sum[19:16];
        sum = sum[15:0] + sum[19:16];
        rep[24] = ~sum[15:8];
        rep[25] = ~sum[7:0];
        n = (cut_len > 0) ? cut_len : req.size();
        for (int i = 0; i < n; i++) begin
            req_q.push_back({user && (i == n - 1), i == n - 1, req[i]});
        end
        if (kind == GOOD && cut_len == 0) begin
            foreach (rep[i]) begin
                exp_q.push_back({user && (i == rep.size() - 1), i == rep.size() - 1, rep[i]});
            end
        end
    endtask

    // Drives all queued request bytes back to back, starting on a falling edge
    task automatic send_frames();
        logic [9:0] item;
        while (req_q.size() > 0) begin
            item = req_q.pop_front();
            {s_tuser, s_tlast, s_tdata} = item;
            s_tvalid = 1'b1;
            do @(posedge clk); while (!s_tready);
            @(negedge clk);
        end
        s_tvalid = 1'b0;
        s_tlast = 1'b0;
        s_tuser = 1'b0;
    endtask

    task automatic check_replies(input string label);
        int n;
        while (got_q.size() < exp_q.size()) @(negedge clk);
        // Room for any unexpected extra output to show up
        repeat (60) @(negedge clk);
        check_value({label, " reply byte count"}, 32'(got_q.size()), 32'(exp_q.size()));
        n = (got_q.size() < exp_q.size()) ? got_q.size() : exp_q.size();
        for (int i = 0; i < n; i++) begin
            check_value($sformatf("%s m_tdata[%0d]", label, i), got_q[i][7:0], exp_q[i][7:0]);
            check_value($sformatf("%s m_tlast[%0d]", label, i), got_q[i][8], exp_q[i][8]);
            check_value($sformatf("%s m_tuser[%0d]", label, i), got_q[i][9], exp_q[i][9]);
        end
        got_q.delete();
        exp_q.delete();
    endtask

    task automatic test_single_echo();
        build_frame(20, GOOD, 0, 1'b0, 1);
        send_frames();
        check_replies("single");
    endtask

    task automatic test_mismatch_drop();
        build_frame(20, BAD_PORT, 0, 1'b0, 2);
        build_frame(20, BAD_IP, 0, 1'b0, 3);
        build_frame(20, BAD_TYPE, 0, 1'b0, 4);
        build_frame(20, BAD_PROTO, 0, 1'b0, 5);
        build_frame(20, GOOD, 0, 1'b0, 6);
        send_frames();
        check_replies("mismatch");
    endtask

    task automatic test_short_frames();
        build_frame(20, GOOD, 42, 1'b0, 7);
        build_frame(20, GOOD, 30, 1'b0, 8);
        build_frame(20, GOOD, 1, 1'b0, 9);
        build_frame(20, GOOD, 0, 1'b0, 10);
        send_frames();
        check_replies("short");
    endtask

    task automatic test_back_to_back();
        int len;
        rand_ready = 1'b1;
        for (int k = 0; k < 6; k++) begin
            pay_rng = xorshift32(pay_rng);
            len = (k == 0) ? 1 : (k == 5) ? 300 : 1 + int'(pay_rng % 300);
            build_frame(len, GOOD, 0, 1'b0, 11 + k);
        end
        send_frames();
        check_replies("back_to_back");
        rand_ready = 1'b0;
    endtask

    task automatic test_user_flag();
        build_frame(20, GOOD, 0, 1'b1, 20);
        build_frame(20, GOOD, 0, 1'b0, 21);
        send_frames();
        check_replies("user_flag");
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        s_tdata = '0;
        s_tvalid = 1'b0;
        s_tlast = 1'b0;
        s_tuser = 1'b0;
        m_tready = 1'b1;
        rand_ready = 1'b0;
        pay_rng = SEED;
        rdy_rng = SEED;
        errors = 0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        // Input side ready one cycle out of reset
        @(negedge clk);
        check_value("s_tready", 32'(s_tready), 32'h1);
        test_single_echo();
        test_mismatch_drop();
        test_short_frames();
        test_back_to_back();
        test_user_flag();
        $display("Run finished with %0d check errors and %0d assertion failures",
                 errors, uut.asserts.fail_count);
        if (errors == 0 && uut.asserts.fail_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== tests/tb_udp_echo_assert.sv ====
// Stream protocol assertions bound to the echo responder top level by the testbench
module tb_udp_echo_assert (
    input logic       clk,
    input logic       rst,
    input logic [7:0] m_tdata,
    input logic       m_tvalid,
    input logic       m_tready,
    input logic       m_tlast,
    input logic       m_tuser
);
    timeunit 1ns;
    timeprecision 1ps;

    // Read by the testbench when the run ends
    int fail_count = 0;

    idle_in_reset: assert property (@(posedge clk) rst |=> !m_tvalid)
        else begin
            fail_count++;
            $error("m_tvalid high while in reset");
        end

    // A stalled beat keeps valid and holds its contents
    valid_held: assert property (@(posedge clk) disable iff (rst)
        m_tvalid && !m_tready |=> m_tvalid)
        else begin
            fail_count++;
            $error("m_tvalid dropped before the beat was taken");
        end

    beat_stable: assert property (@(posedge clk) disable iff (rst)
        m_tvalid && !m_tready |=> $stable(m_tdata) && $stable(m_tlast) && $stable(m_tuser))
        else begin
            fail_count++;
            $error("Output beat changed while stalled");
        end

endmodule
